//--- Bender.yml
package:
  name: snes_addr

sources:
  - common/snes_map_pkg.sv
  - hdl/mapper_decode.sv
  - hdl/periph_decode.sv
  - hdl/bus_select.sv
  - hdl/snes_addr_top.sv
  - target: test
    files:
      - test/snes_addr_assertions.sv
      - test/snes_addr_tb.sv

//--- common/snes_map_pkg.sv
`default_nettype none

package snes_map_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  typedef logic [23:0] snes_addr_t; // CPU A-bus, also ROM addr / masks
  typedef logic [7:0]  snes_pa_t;   // B-bus peripheral address
  typedef logic [15:0] feature_t;   // Feature enables from MCU

  // Feature bit positions
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Mapper codes as detected by the MCU
  typedef enum logic [2:0] {
    hirom   = 3'b000,
    lorom   = 3'b001,
    exhirom = 3'b010  // 48-64 Mbit images
  } mapper_e;

  // Resource answering a bus cycle
  typedef enum logic [2:0] {
    tgt_none     = 3'd0,
    tgt_rom      = 3'd1,
    tgt_saveram  = 3'd2,
    tgt_msu      = 3'd3,
    tgt_obc1     = 3'd4,
    tgt_snescmd  = 3'd5,
    tgt_hook     = 3'd6
  } target_e;

  // Code hook points inside the command page
  typedef enum logic [2:0] {
    hook_none    = 3'd0,
    hook_nmicmd  = 3'd1,
    hook_return  = 3'd2,
    hook_branch1 = 3'd3,
    hook_branch2 = 3'd4,
    hook_branch3 = 3'd5
  } hook_e;

  ////////////////////////////////////////
  // Decoder results
  ////////////////////////////////////////

  typedef struct packed {
    logic       is_rom;
    logic       is_saveram;
    snes_addr_t rom_addr;    // Already masked / rebased
  } mem_hit_t;

  typedef struct packed {
    logic  msu;
    logic  obc1;
    logic  snescmd;
    logic  r213f;
    logic  r2100;
    hook_e hook;
  } periph_hit_t;

  typedef struct packed {
    target_e    target;
    hook_e      hook;
    snes_addr_t rom_addr;
    logic       rom_hit;  // SRAM access needed
    logic       writable;
    logic       r213f;
    logic       r2100;
  } bus_result_t;

endpackage

`default_nettype wire

//--- hdl/bus_select.sv
`timescale 1ns/10ps
`default_nettype none

module bus_select (
  input  logic                      clk,
  input  logic                      rst_n,
  input  snes_map_pkg::mem_hit_t    mem_hit,
  input  snes_map_pkg::periph_hit_t periph_hit,
  output snes_map_pkg::bus_result_t result
);

  ////////////////////////////////////////
  // Target priority
  ////////////////////////////////////////

  logic                hook_hit;
  snes_map_pkg::target_e next_target;

  assign hook_hit = (periph_hit.hook != snes_map_pkg::hook_none);

  // Hooks sit inside the command page, so they go first
  always_comb begin
    if (hook_hit) begin
      next_target = snes_map_pkg::tgt_hook;
    end else if (periph_hit.snescmd) begin
      next_target = snes_map_pkg::tgt_snescmd;
    end else if (periph_hit.msu) begin
      next_target = snes_map_pkg::tgt_msu;
    end else if (periph_hit.obc1) begin
      next_target = snes_map_pkg::tgt_obc1;   // Overlaps LoROM-less 7800 area
    end else if (mem_hit.is_saveram) begin
      next_target = snes_map_pkg::tgt_saveram;
    end else if (mem_hit.is_rom) begin
      next_target = snes_map_pkg::tgt_rom;
    end else begin
      next_target = snes_map_pkg::tgt_none;
    end
  end

  ////////////////////////////////////////
  // Next result
  ////////////////////////////////////////

  snes_map_pkg::bus_result_t next_result;

  always_comb begin
    next_result.target   = next_target;
    next_result.hook     = periph_hit.hook;
    next_result.rom_addr = mem_hit.rom_addr;
    // SRAM chip is used by both ROM and save RAM
    next_result.rom_hit  = mem_hit.is_rom | mem_hit.is_saveram;
    next_result.writable = mem_hit.is_saveram;  // Only save RAM takes writes
    // B-bus flags independent of A-bus target
    next_result.r213f    = periph_hit.r213f;
    next_result.r2100    = periph_hit.r2100;
  end

  ////////////////////////////////////////
  // Pipeline register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result.target   <= snes_map_pkg::tgt_none;
      result.hook     <= snes_map_pkg::hook_none;
      result.rom_addr <= '0;
      result.rom_hit  <= 1'b0;
      result.writable <= 1'b0;
      result.r213f    <= 1'b0;
      result.r2100    <= 1'b0;
    end else begin
      result <= next_result;  // One decode per cycle
    end
  end

endmodule

`default_nettype wire

//--- hdl/mapper_decode.sv
`timescale 1ns/10ps
`default_nettype none

module mapper_decode #(
  parameter snes_map_pkg::snes_addr_t SAVERAM_BASE = 24'hE00000
) (
  input  snes_map_pkg::mapper_e    mapper,
  input  snes_map_pkg::snes_addr_t snes_addr,
  input  logic                     snes_romsel,
  input  snes_map_pkg::snes_addr_t rom_mask,
  input  snes_map_pkg::snes_addr_t saveram_mask,
  output snes_map_pkg::mem_hit_t   mem_hit
);

  ////////////////////////////////////////
  // Window classification
  ////////////////////////////////////////

  logic rom_area;   // Upper half of bank or banks 40+
  logic hi_window;  // HiROM style save RAM window
  logic lo_window;  // LoROM style save RAM window
  logic sram_win;   // Window for the active mapper
  logic is_sram;

  // Bit 22 covers 40-7D / C0-FF, bit 15 the upper half below
  assign rom_area = snes_addr[22] | snes_addr[15];

  // Banks 30-3F / B0-BF, offsets 6000-7FFF
  assign hi_window = ~snes_addr[22] & snes_addr[21] & snes_addr[20]
                   & ~snes_addr[15] & snes_addr[14] & snes_addr[13];

  // Banks 70-7F / F0-FF, cart selected via ROMSEL
  assign lo_window = (&snes_addr[22:20])
                   & ~snes_romsel
                   & (~snes_addr[15] | ~rom_mask[21]); // big ROM owns upper half

  always_comb begin
    case (mapper)
      snes_map_pkg::hirom,
      snes_map_pkg::exhirom: sram_win = hi_window;
      snes_map_pkg::lorom:   sram_win = lo_window;
      default:               sram_win = 1'b0;  // Unknown mapper
    endcase
  end

  assign is_sram = saveram_mask[0] & sram_win; // Mask bit 0 means RAM present

  ////////////////////////////////////////
  // Address translation
  ////////////////////////////////////////

  snes_map_pkg::snes_addr_t hi_sram_off;  // 8 KB pages per bank
  snes_map_pkg::snes_addr_t lo_sram_off;  // 32 KB pages per bank
  snes_map_pkg::snes_addr_t rom_hi;
  snes_map_pkg::snes_addr_t rom_lo;
  snes_map_pkg::snes_addr_t rom_ex;
  snes_map_pkg::snes_addr_t xlat_addr;

  // Bank bits packed above offset bits
  assign hi_sram_off = {6'd0, snes_addr[20:16], snes_addr[12:0]};
  assign lo_sram_off = {4'd0, snes_addr[20:16], snes_addr[14:0]};

  assign rom_hi = {1'b0, snes_addr[22:0]};                  // Mirror 80+ onto 00+
  assign rom_lo = {2'b00, snes_addr[22:16], snes_addr[14:0]}; // Drop A15
  assign rom_ex = {1'b0, ~snes_addr[23], snes_addr[21:0]};  // C0+ first, 40+ second

  always_comb begin
    xlat_addr = '0;
    case (mapper)
      snes_map_pkg::hirom: begin
        if (is_sram) begin
          xlat_addr = SAVERAM_BASE + (hi_sram_off & saveram_mask);
        end else begin
          xlat_addr = rom_hi & rom_mask;
        end
      end
      snes_map_pkg::lorom: begin
        if (is_sram) begin
          xlat_addr = SAVERAM_BASE + (lo_sram_off & saveram_mask);
        end else begin
          xlat_addr = rom_lo & rom_mask;
        end
      end
      snes_map_pkg::exhirom: begin
        if (is_sram) begin
          xlat_addr = SAVERAM_BASE + (hi_sram_off & saveram_mask); // Same as HiROM
        end else begin
          xlat_addr = rom_ex & rom_mask;
        end
      end
      default: begin
        xlat_addr = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Result
  ////////////////////////////////////////

  always_comb begin
    mem_hit.is_rom     = rom_area;
    mem_hit.is_saveram = is_sram;
    mem_hit.rom_addr   = xlat_addr;
  end

endmodule

`default_nettype wire

//--- hdl/periph_decode.sv
`timescale 1ns/10ps
`default_nettype none

module periph_decode (
  input  snes_map_pkg::feature_t    featurebits,
  input  snes_map_pkg::snes_addr_t  snes_addr,
  input  snes_map_pkg::snes_pa_t    snes_pa,
  output snes_map_pkg::periph_hit_t periph_hit
);

  ////////////////////////////////////////
  // A-bus windows
  ////////////////////////////////////////

  logic low_bank;     // System area banks, A22 clear
  logic msu_win;
  logic obc1_win;
  logic cmd_win;

  assign low_bank = ~snes_addr[22];

  // MSU-1 register file, 2000-2007
  assign msu_win = low_bank & (snes_addr[15:3] == 13'h0400);

  // OBC1 sprite RAM window, 7800-7FFF
  assign obc1_win = low_bank & (snes_addr[15:11] == 5'b01111);

  // Command page 2A00-2BFF
  assign cmd_win = low_bank & (snes_addr[15:9] == 7'b0010101);

  ////////////////////////////////////////
  // B-bus registers
  ////////////////////////////////////////

  logic pa_213f;
  logic pa_2100;

  assign pa_213f = (snes_pa == 8'h3F);  // PPU2 status, region bit
  assign pa_2100 = (snes_pa == 8'h00);  // INIDISP write seen

  ////////////////////////////////////////
  // Hook addresses
  ////////////////////////////////////////

  snes_map_pkg::hook_e hook_sel;

  // Full 24-bit compare, at most one can match
  always_comb begin
    case (snes_addr)
      24'h002BF2: hook_sel = snes_map_pkg::hook_nmicmd;
      24'h002A6C: hook_sel = snes_map_pkg::hook_return;
      24'h002A1F: hook_sel = snes_map_pkg::hook_branch1;
      24'h002A59: hook_sel = snes_map_pkg::hook_branch2;
      24'h002A5E: hook_sel = snes_map_pkg::hook_branch3;
      default:    hook_sel = snes_map_pkg::hook_none;
    endcase
  end

  ////////////////////////////////////////
  // Feature gating and output
  ////////////////////////////////////////

  always_comb begin
    periph_hit.msu     = featurebits[snes_map_pkg::FEAT_MSU1] & msu_win;
    periph_hit.obc1    = obc1_win;
    periph_hit.snescmd = cmd_win;
    periph_hit.r213f   = featurebits[snes_map_pkg::FEAT_213F] & pa_213f;
    periph_hit.r2100   = pa_2100;    // Always on
    periph_hit.hook    = hook_sel;
  end

endmodule

`default_nettype wire

//--- hdl/snes_addr_top.sv
`timescale 1ns/10ps
`default_nettype none

module snes_addr_top #(
  parameter snes_map_pkg::snes_addr_t SAVERAM_BASE = 24'hE00000  // Save RAM in upper SRAM
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  snes_map_pkg::mapper_e     mapper,
  input  snes_map_pkg::feature_t    featurebits,
  input  snes_map_pkg::snes_addr_t  snes_addr,
  input  snes_map_pkg::snes_pa_t    snes_pa,
  input  logic                      snes_romsel,
  input  snes_map_pkg::snes_addr_t  rom_mask,
  input  snes_map_pkg::snes_addr_t  saveram_mask,
  output snes_map_pkg::bus_result_t result
);

  ////////////////////////////////////////
  // Decoder outputs
  ////////////////////////////////////////

  snes_map_pkg::mem_hit_t    mem_hit;
  snes_map_pkg::periph_hit_t periph_hit;

  // Memory map, ROM / save RAM
  mapper_decode #(
    .SAVERAM_BASE (SAVERAM_BASE)
  ) u_mapper_decode (
    .mapper       (mapper),
    .snes_addr    (snes_addr),
    .snes_romsel  (snes_romsel),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .mem_hit      (mem_hit)
  );

  // Registers, windows and hooks
  periph_decode u_periph_decode (
    .featurebits (featurebits),
    .snes_addr   (snes_addr),
    .snes_pa     (snes_pa),
    .periph_hit  (periph_hit)
  );

  // Priority select, single register stage
  bus_select u_bus_select (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_hit    (mem_hit),
    .periph_hit (periph_hit),
    .result     (result)
  );

endmodule

`default_nettype wire

//--- test/snes_addr_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module snes_addr_assertions (
  input logic                      clk,
  input logic                      rst_n,
  input snes_map_pkg::bus_result_t result
);

  ////////////////////////////////////////
  // Output properties
  ////////////////////////////////////////

  // Reset edge clears the target
  property p_reset_clears;
    @(posedge clk) !rst_n |=> (result.target == snes_map_pkg::tgt_none);
  endproperty

  // Writes only into SRAM space
  property p_writable_rom_hit;
    @(posedge clk) disable iff (!rst_n)
      result.writable |-> result.rom_hit;
  endproperty

  // Hook target and hook code agree
  property p_hook_consistent;
    @(posedge clk) disable iff (!rst_n)
      (result.target == snes_map_pkg::tgt_hook) == (result.hook != snes_map_pkg::hook_none);
  endproperty

  a_reset_clears: assert property (p_reset_clears)
    else $error("target not tgt_none after a reset cycle");
  a_writable_rom_hit: assert property (p_writable_rom_hit)
    else $error("writable set without rom_hit");
  a_hook_consistent: assert property (p_hook_consistent)
    else $error("tgt_hook and hook field disagree");

endmodule

bind bus_select snes_addr_assertions u_snes_addr_assertions (
  .clk    (clk),
  .rst_n  (rst_n),
  .result (result)
);

`default_nettype wire

//--- test/snes_addr_tb.sv
`timescale 1ns/10ps
`default_nettype none

module snes_addr_tb;

  localparam TEST_FILE = "test/snes_addr_tests.txt";  // Relative to project root

  // One bus cycle as presented by the console
  typedef struct packed {
    snes_map_pkg::mapper_e    mapper;
    snes_map_pkg::feature_t   featurebits;
    snes_map_pkg::snes_addr_t snes_addr;
    snes_map_pkg::snes_pa_t   snes_pa;
    logic                     snes_romsel;
    snes_map_pkg::snes_addr_t rom_mask;
    snes_map_pkg::snes_addr_t saveram_mask;
  } stim_t;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                      clk;
  logic                      rst_n;
  snes_map_pkg::mapper_e     mapper;
  snes_map_pkg::feature_t    featurebits;
  snes_map_pkg::snes_addr_t  snes_addr;
  snes_map_pkg::snes_pa_t    snes_pa;
  logic                      snes_romsel;
  snes_map_pkg::snes_addr_t  rom_mask;
  snes_map_pkg::snes_addr_t  saveram_mask;
  snes_map_pkg::bus_result_t result;

  snes_map_pkg::bus_result_t exp_q[$];  // One entry per vector in flight
  int n_vec       = 0;
  int n_checked   = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;                  // Zero until vectors counted

  snes_addr_top #(
    .SAVERAM_BASE (24'hE00000)
  ) UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .mapper       (mapper),
    .featurebits  (featurebits),
    .snes_addr    (snes_addr),
    .snes_pa      (snes_pa),
    .snes_romsel  (snes_romsel),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .result       (result)
  );

  // 8 ns period
  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Vector file handling
  ////////////////////////////////////////

  // Returns 1 for a full vector line, 0 for comments and blanks
  function automatic bit parse_line(input string line, output stim_t s,
                                    output snes_map_pkg::bus_result_t e);
    logic [23:0] f [0:13];
    int          n;
    s = '0;
    e = '0;
    if (line.len() == 0) return 0;
    if (line.getc(0) == "#") return 0;  // Column legend
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
    if (n != 14) return 0;
    s.mapper       = snes_map_pkg::mapper_e'(f[0][2:0]);
    s.featurebits  = f[1][15:0];
    s.snes_addr    = f[2];
    s.snes_pa      = f[3][7:0];
    s.snes_romsel  = f[4][0];
    s.rom_mask     = f[5];
    s.saveram_mask = f[6];
    e.target       = snes_map_pkg::target_e'(f[7][2:0]);
    e.hook         = snes_map_pkg::hook_e'(f[8][2:0]);
    e.rom_addr     = f[9];
    e.rom_hit      = f[10][0];
    e.writable     = f[11][0];
    e.r213f        = f[12][0];
    e.r2100        = f[13][0];
    return 1;
  endfunction

  task automatic count_vectors(output int count);
    int                        fd;
    string                     line;
    stim_t                     s;
    snes_map_pkg::bus_result_t e;
    count = 0;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", TEST_FILE);
      $display("TEST FAIL");
      $fatal(1, "vector file missing");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0) begin
        if (parse_line(line, s, e)) count++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Drive and compare
  ////////////////////////////////////////

  task automatic apply_stimulus(input stim_t s);
    mapper       <= s.mapper;
    featurebits  <= s.featurebits;
    snes_addr    <= s.snes_addr;
    snes_pa      <= s.snes_pa;
    snes_romsel  <= s.snes_romsel;
    rom_mask     <= s.rom_mask;
    saveram_mask <= s.saveram_mask;
  endtask

  task automatic check_field(input string name, input logic [23:0] exp_val,
                             input logic [23:0] act_val);
    assert (act_val === exp_val) else begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
               $time, name, exp_val, act_val);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic compare_result(input snes_map_pkg::bus_result_t e);
    check_field("result.target",   e.target,   result.target);
    check_field("result.hook",     e.hook,     result.hook);
    check_field("result.rom_addr", e.rom_addr, result.rom_addr);
    check_field("result.rom_hit",  e.rom_hit,  result.rom_hit);
    check_field("result.writable", e.writable, result.writable);
    check_field("result.r213f",    e.r213f,    result.r213f);
    check_field("result.r2100",    e.r2100,    result.r2100);
  endtask

  ////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout, no end of test after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : run_tests
    int                        fd;
    string                     line;
    stim_t                     s;
    snes_map_pkg::bus_result_t e;
    snes_map_pkg::bus_result_t exp_now;
    rst_n        = 1'b0;
    mapper       = snes_map_pkg::hirom;
    featurebits  = '0;
    snes_addr    = 24'hC00000;  // ROM address, so a cleared result means reset worked
    snes_pa      = 8'hFF;
    snes_romsel  = 1'b1;
    rom_mask     = 24'h3FFFFF;
    saveram_mask = 24'h001FFF;
    count_vectors(n_vec);
    cycle_limit = n_vec + 20;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    exp_now = '0;               // tgt_none, hook_none, flags low
    compare_result(exp_now);

    fd = $fopen(TEST_FILE, "r");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0) begin
        if (parse_line(line, s, e)) begin
          @(posedge clk);
          apply_stimulus(s);
          exp_q.push_back(e);
          @(negedge clk);
          if (exp_q.size() > 1) begin  // Previous vector has landed
            exp_now = exp_q.pop_front();
            compare_result(exp_now);
            n_checked++;
          end
        end
      end
    end
    $fclose(fd);

    // Last vector needs one more edge
    @(posedge clk);
    @(negedge clk);
    if (exp_q.size() == 1) begin
      exp_now = exp_q.pop_front();
      compare_result(exp_now);
      n_checked++;
    end

    if (n_vec > 0 && n_checked == n_vec) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Only %0d of %0d vectors were checked", n_checked, n_vec);
      $display("TEST FAIL");
      $fatal(1, "incomplete run");
    end
  end

endmodule

`default_nettype wire

//--- test/snes_addr_tests.txt
# mapper feat addr pa romsel rom_mask sram_mask | target hook rom_addr rom_hit wr r213f r2100
# mapper 0=hirom 1=lorom 2=exhirom, target 0=none 1=rom 2=sram 3=msu 4=obc1 5=cmd 6=hook
0 0018 C01234 FF 1 3FFFFF 001FFF 1 0 001234 1 0 0 0
0 0018 808000 FF 1 3FFFFF 001FFF 1 0 008000 1 0 0 0
0 0018 FE5678 FF 1 0FFFFF 001FFF 1 0 0E5678 1 0 0 0
2 0018 3F8000 FF 1 7FFFFF 001FFF 1 0 7F8000 1 0 0 0
2 0018 C12345 FF 1 7FFFFF 001FFF 1 0 012345 1 0 0 0
2 0018 008000 FF 1 7FFFFF 001FFF 1 0 408000 1 0 0 0
0 0018 306123 FF 1 3FFFFF 001FFF 2 0 E00123 1 1 0 0
0 0018 B16123 FF 1 3FFFFF 00FFFF 2 0 E02123 1 1 0 0
1 0018 700456 FF 0 3FFFFF 001FFF 2 0 E00456 1 1 0 0
1 0018 700456 FF 1 3FFFFF 001FFF 1 0 380456 1 0 0 0
1 0018 F08123 FF 0 1FFFFF 001FFF 2 0 E00123 1 1 0 0
1 0018 F08123 FF 0 3FFFFF 001FFF 1 0 380123 1 0 0 0
0 0018 306123 FF 1 3FFFFF 000000 0 0 306123 0 0 0 0
1 0018 700456 FF 0 3FFFFF 000000 1 0 380456 1 0 0 0
0 0018 002000 FF 1 3FFFFF 001FFF 3 0 002000 0 0 0 0
0 0010 802007 FF 1 3FFFFF 001FFF 0 0 002007 0 0 0 0
0 0008 002007 FF 1 3FFFFF 001FFF 3 0 002007 0 0 0 0
0 0018 002008 FF 1 3FFFFF 001FFF 0 0 002008 0 0 0 0
0 0018 000000 3F 1 3FFFFF 001FFF 0 0 000000 0 0 1 0
0 0008 000000 3F 1 3FFFFF 001FFF 0 0 000000 0 0 0 0
0 0000 C01234 00 1 3FFFFF 001FFF 1 0 001234 1 0 0 1
0 0018 000000 00 1 3FFFFF 001FFF 0 0 000000 0 0 0 1
0 0018 002BF2 FF 1 3FFFFF 001FFF 6 1 002BF2 0 0 0 0
0 0018 002A6C FF 1 3FFFFF 001FFF 6 2 002A6C 0 0 0 0
0 0018 002A1F FF 1 3FFFFF 001FFF 6 3 002A1F 0 0 0 0
0 0018 002A59 FF 1 3FFFFF 001FFF 6 4 002A59 0 0 0 0
0 0018 002A5E FF 1 3FFFFF 001FFF 6 5 002A5E 0 0 0 0
0 0018 002A00 FF 1 3FFFFF 001FFF 5 0 002A00 0 0 0 0
0 0018 802BF2 FF 1 3FFFFF 001FFF 5 0 002BF2 0 0 0 0
0 0018 007800 FF 1 3FFFFF 001FFF 4 0 007800 0 0 0 0
0 0018 307FFF FF 1 3FFFFF 001FFF 4 0 E01FFF 1 1 0 0
0 0018 C01234 FF 1 3FFFFF 001FFF 1 0 001234 1 0 0 0
0 0018 002A6C FF 1 3FFFFF 001FFF 6 2 002A6C 0 0 0 0
0 0018 306123 FF 1 3FFFFF 001FFF 2 0 E00123 1 1 0 0
0 0018 002000 FF 1 3FFFFF 001FFF 3 0 002000 0 0 0 0
0 0018 C01234 00 1 3FFFFF 001FFF 1 0 001234 1 0 0 1
0 0018 000000 FF 1 3FFFFF 001FFF 0 0 000000 0 0 0 0

//--- verilog.f
common/snes_map_pkg.sv
hdl/mapper_decode.sv
hdl/periph_decode.sv
hdl/bus_select.sv
hdl/snes_addr_top.sv
test/snes_addr_assertions.sv
test/snes_addr_tb.sv
